// File: bench/softex_stimulus.txt
// cmd (0 clear, 1 accumulate, 2 normalize, F end), byte strobes, scores of lanes 0..3,
// then expected max_o (accumulate) or expected probabilities of lanes 0..3 (normalize)
1 FF 000A 0008 0003 FFEC 000A 0000 0000 0000
1 7F 0009 000B 0004 01F4 000B 0000 0000 0000
2 CF 000B 0009 000A 0000 43D7 10F5 0000 0008
2 FF FFFB 000B 0003 0007 0000 43D7 0043 043D
1 FF 0064 00C8 012C 0190 0190 0000 0000 0000
0 00 0000 0000 0000 0000 0000 0000 0000 0000
1 FF 0014 0012 0013 0010 0014 0000 0000 0000
1 FF 0016 0015 0005 0014 0016 0000 0000 0000
1 FF 0019 000A 0018 0017 0019 0000 0000 0000
1 FF 000F 0018 0015 0019 0019 0000 0000 0000
1 3C 0028 000C 0014 0032 0019 0000 0000 0000
2 FF 0019 0018 0016 0009 235B 11AD 046B 0000
2 F3 0017 0019 0019 0014 08D6 0000 235B 011A
2 FF 0015 0012 000E 000A 0235 0046 0004 0000
0 00 0000 0000 0000 0000 0000 0000 0000 0000
1 03 0007 0064 00C8 012C 0007 0000 0000 0000
2 FF 0007 0006 0000 FF9C 7FFF 4000 0100 0000
2 FF 0001 0002 0003 0004 0200 0400 0800 1000
2 0C 0007 0007 0007 0007 0000 7FFF 0000 0000
F 00 0000 0000 0000 0000 0000 0000 0000 0000

// File: softex_lite.f
hdl/softex_num_pkg.sv
hdl/softex_ctrl_pkg.sv
hdl/softex_stage_ifs.sv
hdl/softex_decode.sv
hdl/softex_execute.sv
hdl/softex_result.sv
hdl/softex_top.sv
bench/softex_assertions.sv
bench/softex_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the softmax testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f softex_lite.f \
    --top-module softex_tb \
    -Mdir obj_dir

# The log decides the result, so a failing run must not stop the script here
./obj_dir/Vsoftex_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "Simulation result: pass"
    exit 0
fi

echo "Simulation result: fail"
exit 1

// File: bench/softex_tb.sv
//##########################################################################
// Reads bench/softex_stimulus.txt, so it must run from the project root.
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

module softex_tb;

    localparam int unsigned VW        = softex_num_pkg::VECT_WIDTH;
    localparam int unsigned SPL       = softex_num_pkg::STRB_PER_LANE;
    localparam int unsigned REC_WORDS = 2 + 2 * VW;
    localparam int unsigned MAX_RECS  = 64;
    localparam int          CLK_HALF  = 10;
    localparam int          SAMPLE_DELAY = 5;
    localparam logic [15:0] LFSR_SEED = 16'd40903;
    localparam logic [31:0] CMD_CLEAR     = 32'h0;
    localparam logic [31:0] CMD_NORMALIZE = 32'h2;
    localparam logic [31:0] CMD_END       = 32'hF;

    logic                                   clk_i;
    logic                                   rst_ni;
    logic                                   clear_i;
    logic                                   in_valid_i;
    logic                                   in_ready_o;
    softex_num_pkg::score_t [VW-1:0]        in_data_i;
    logic [VW*SPL-1:0]                      in_strb_i;
    softex_ctrl_pkg::mode_e                 mode_i;
    logic                                   out_valid_o;
    logic                                   out_ready_i;
    softex_num_pkg::prob_t [VW-1:0]         out_data_o;
    logic [VW-1:0]                          out_strb_o;
    softex_num_pkg::score_t                 max_o;
    logic                                   busy_o;

    logic [31:0]                            stim_mem [REC_WORDS*MAX_RECS];
    softex_num_pkg::prob_t [VW-1:0]         exp_data_q [$];
    logic [VW-1:0]                          exp_strb_q [$];
    int                                     cycle_limit = 0;
    int                                     cycle_count = 0;

    softex_top #(.VECT_WIDTH(VW)) uut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .in_strb_i   (in_strb_i),
        .mode_i      (mode_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o),
        .out_strb_o  (out_strb_o),
        .max_o       (max_o),
        .busy_o      (busy_o)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 16'hB400;
        end
        return nxt;
    endfunction

    // A lane counts only when every byte of it is strobed
    function automatic logic [VW-1:0] lane_strobes(input logic [VW*SPL-1:0] bytes);
        logic [VW-1:0] lanes;
        for (int i = 0; i < VW; i++) begin
            lanes[i] = &bytes[i*SPL +: SPL];
        end
        return lanes;
    endfunction

    function automatic int count_records();
        for (int r = 0; r < MAX_RECS; r++) begin
            if ($isunknown(stim_mem[r*REC_WORDS])) begin
                return -1;
            end
            if (stim_mem[r*REC_WORDS] == CMD_END) begin
                return r;
            end
        end
        return -1;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_until_idle();
        @(posedge clk_i);
        #(SAMPLE_DELAY);
        while (exp_data_q.size() != 0 || busy_o) begin
            @(posedge clk_i);
            #(SAMPLE_DELAY);
        end
    endtask

    task automatic send_vector(input int base);
        softex_num_pkg::prob_t [VW-1:0] exp_data;
        logic                           is_norm;
        is_norm = stim_mem[base] == CMD_NORMALIZE;
        @(negedge clk_i);
        in_valid_i = 1'b1;
        in_strb_i  = stim_mem[base+1][VW*SPL-1:0];
        mode_i     = is_norm ? softex_ctrl_pkg::NORMALIZE : softex_ctrl_pkg::ACCUMULATE;
        for (int i = 0; i < VW; i++) begin
            in_data_i[i] = stim_mem[base+2+i][softex_num_pkg::SCORE_W-1:0];
            exp_data[i]  = stim_mem[base+2+VW+i][softex_num_pkg::PROB_W-1:0];
        end
        #(SAMPLE_DELAY);
        while (!in_ready_o) begin
            @(negedge clk_i);
            #(SAMPLE_DELAY);
        end
        if (is_norm) begin
            exp_data_q.push_back(exp_data);
            exp_strb_q.push_back(lane_strobes(in_strb_i));
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
        if (!is_norm) begin
            #(SAMPLE_DELAY);
            check_value("max_o", {16'h0, max_o}, stim_mem[base+2+VW]);
        end
    endtask

    task automatic apply_clear();
        wait_until_idle();
        @(negedge clk_i);
        clear_i = 1'b1;
        @(negedge clk_i);
        clear_i = 1'b0;
        #(SAMPLE_DELAY);
        check_value("max_o after clear", {16'h0, max_o}, 32'h0);
        check_value("busy_o after clear", busy_o, 32'h0);
        check_value("in_ready_o after clear", in_ready_o, 32'h1);
    endtask

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_HALF);
            clk_i = ~clk_i;
        end
    end

    initial begin : watchdog
        wait (cycle_limit != 0);
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                abort_run("The run timed out before all expected outputs had arrived");
            end
        end
    end

    // Random back-pressure, and every output taken is checked against the queue
    initial begin : output_side
        logic [15:0]                    lfsr;
        softex_num_pkg::prob_t [VW-1:0] exp_data;
        logic [VW-1:0]                  exp_strb;
        lfsr        = LFSR_SEED;
        out_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            out_ready_i = lfsr[0];
            lfsr        = lfsr_next(lfsr);
            #(SAMPLE_DELAY);
            if (out_valid_o && out_ready_i) begin
                if (exp_data_q.size() == 0) begin
                    abort_run("An output vector arrived that no input vector asked for");
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_strb = exp_strb_q.pop_front();
                    for (int i = 0; i < VW; i++) begin
                        check_value($sformatf("out_data_o lane %0d", i), out_data_o[i],
                                    exp_data[i]);
                    end
                    check_value("out_strb_o", out_strb_o, exp_strb);
                end
            end
        end
    end

    initial begin : stimulus
        int n_recs;
        rst_ni     = 1'b0;
        clear_i    = 1'b0;
        in_valid_i = 1'b0;
        in_data_i  = '0;
        in_strb_i  = '0;
        mode_i     = softex_ctrl_pkg::ACCUMULATE;
        $readmemh("bench/softex_stimulus.txt", stim_mem);
        n_recs = count_records();
        if (n_recs <= 0) begin
            abort_run("The stimulus file could not be read or has no end record");
        end
        cycle_limit = 40 * n_recs + 200;
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int r = 0; r < n_recs; r++) begin
            if (stim_mem[r*REC_WORDS] == CMD_CLEAR) begin
                apply_clear();
            end else begin
                send_vector(r * REC_WORDS);
            end
        end
        wait_until_idle();
        @(negedge clk_i);
        if (uut.u_assertions.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", uut.u_assertions.fail_count);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: bench/softex_assertions.sv
//##########################################################################
// Handshake and reset rules for softex_top. The DUT is reached through bind.
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

module softex_assertions #(
    parameter int unsigned VECT_WIDTH = softex_num_pkg::VECT_WIDTH
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    clear_i,
    input  logic                                    in_ready_i,
    input  logic                                    out_valid_i,
    input  logic                                    out_ready_i,
    input  softex_num_pkg::prob_t [VECT_WIDTH-1:0]  out_data_i,
    input  logic                                    busy_i,
    input  softex_ctrl_pkg::div_state_e             div_state_i
);

    int unsigned fail_count = 0;

    // A stalled output item keeps both its valid and its data
    out_held: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else begin
        fail_count++;
        $error("out_valid_o or out_data_o changed while out_ready_i was low");
    end

    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !busy_i && !out_valid_i)
    else begin
        fail_count++;
        $error("busy_o or out_valid_o high in the first cycle after reset");
    end

    // Once the input has stalled behind the divider it stays stalled until the end
    stall_during_div: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        div_state_i == softex_ctrl_pkg::DIV_RUN && !in_ready_i
        |=> div_state_i != softex_ctrl_pkg::DIV_RUN || !in_ready_i)
    else begin
        fail_count++;
        $error("in_ready_o rose while the reciprocal division was running");
    end

endmodule

bind softex_top softex_assertions #(.VECT_WIDTH(VECT_WIDTH)) u_assertions (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_i  (out_data_o),
    .busy_i      (busy_o),
    .div_state_i (i_result.div_state)
);

`default_nettype wire

// File: hdl/softex_top.sv
//##########################################################################
// Integer softmax: three one-cycle stages, up to three items in flight.
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

module softex_top #(
    parameter int unsigned VECT_WIDTH = softex_num_pkg::VECT_WIDTH
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        clear_i,
    input  logic                                        in_valid_i,
    output logic                                        in_ready_o,
    input  softex_num_pkg::score_t [VECT_WIDTH-1:0]     in_data_i,
    input  logic [VECT_WIDTH*softex_num_pkg::STRB_PER_LANE-1:0] in_strb_i,
    input  softex_ctrl_pkg::mode_e                      mode_i,
    output logic                                        out_valid_o,
    input  logic                                        out_ready_i,
    output softex_num_pkg::prob_t [VECT_WIDTH-1:0]      out_data_o,
    output logic [VECT_WIDTH-1:0]                       out_strb_o,
    output softex_num_pkg::score_t                      max_o,
    output logic                                        busy_o
);

    logic dec_busy;
    logic exe_busy;
    logic res_busy;

    softex_score_if  #(.VECT_WIDTH(VECT_WIDTH)) score_link ();
    softex_weight_if #(.VECT_WIDTH(VECT_WIDTH)) weight_link ();

    softex_decode #(.VECT_WIDTH(VECT_WIDTH)) i_decode (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (clear_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_data_i  (in_data_i),
        .in_strb_i  (in_strb_i),
        .mode_i     (mode_i),
        .max_o      (max_o),
        .busy_o     (dec_busy),
        .score_o    (score_link.source)
    );

    softex_execute #(.VECT_WIDTH(VECT_WIDTH)) i_execute (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (clear_i),
        .score_i    (score_link.sink),
        .weight_o   (weight_link.source),
        .busy_o     (exe_busy)
    );

    softex_result #(.VECT_WIDTH(VECT_WIDTH)) i_result (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .weight_i    (weight_link.sink),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o),
        .out_strb_o  (out_strb_o),
        .busy_o      (res_busy)
    );

    assign busy_o = dec_busy | exe_busy | res_busy;

endmodule

`default_nettype wire

// File: hdl/softex_result.sv
//##########################################################################
// The reciprocal is computed once after each clear; ACCUMULATE items sent
// after the first NORMALIZE item do not refresh it.
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

module softex_result #(
    parameter int unsigned VECT_WIDTH = softex_num_pkg::VECT_WIDTH
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    clear_i,
    softex_weight_if.sink                           weight_i,
    output logic                                    out_valid_o,
    input  logic                                    out_ready_i,
    output softex_num_pkg::prob_t [VECT_WIDTH-1:0]  out_data_o,
    output logic [VECT_WIDTH-1:0]                   out_strb_o,
    output logic                                    busy_o
);

    localparam int unsigned DEN_W   = softex_num_pkg::DEN_W;
    localparam int unsigned RECIP_W = softex_num_pkg::RECIP_W;
    localparam int unsigned PROD_W  = softex_num_pkg::WEIGHT_W + RECIP_W;

    softex_ctrl_pkg::div_state_e    div_state;
    logic [4:0]                     div_cnt;
    softex_num_pkg::den_t           rem_q;
    logic [DEN_W-1:0]               quo_q;
    logic [DEN_W:0]                 rem_shift;
    logic                           q_bit;
    logic                           is_norm;
    logic                           out_free;
    logic                           take_norm;
    logic                           div_start;
    softex_num_pkg::recip_t         recip;
    logic [PROD_W-1:0]              prod [VECT_WIDTH];
    softex_num_pkg::prob_t [VECT_WIDTH-1:0] prob;

    assign is_norm   = weight_i.mode == softex_ctrl_pkg::NORMALIZE;
    assign out_free  = !out_valid_o || out_ready_i;
    assign div_start = weight_i.valid && is_norm && div_state == softex_ctrl_pkg::DIV_IDLE;

    // ACCUMULATE items are always taken and dropped here
    assign weight_i.ready = is_norm ?
        (div_state == softex_ctrl_pkg::DIV_DONE && out_free) : 1'b1;
    assign take_norm = weight_i.valid && weight_i.ready && is_norm;

    // Restoring division of 2^31, whose only set bit enters on the first step
    assign rem_shift = {rem_q, div_cnt == 5'd0};
    assign q_bit     = rem_shift >= {1'b0, weight_i.den};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            div_state <= softex_ctrl_pkg::DIV_IDLE;
            div_cnt   <= '0;
            rem_q     <= '0;
            quo_q     <= '0;
        end else if (clear_i) begin
            div_state <= softex_ctrl_pkg::DIV_IDLE;
            div_cnt   <= '0;
            rem_q     <= '0;
            quo_q     <= '0;
        end else begin
            case (div_state)
                softex_ctrl_pkg::DIV_IDLE: begin
                    if (div_start) begin
                        div_state <= softex_ctrl_pkg::DIV_RUN;
                        div_cnt   <= '0;
                        rem_q     <= '0;
                        quo_q     <= '0;
                    end
                end
                softex_ctrl_pkg::DIV_RUN: begin
                    rem_q   <= q_bit ? DEN_W'(rem_shift - {1'b0, weight_i.den})
                                     : rem_shift[DEN_W-1:0];
                    quo_q   <= {quo_q[DEN_W-2:0], q_bit};
                    div_cnt <= div_cnt + 5'd1;
                    if (div_cnt == 5'd31) begin
                        div_state <= softex_ctrl_pkg::DIV_DONE;
                    end
                end
                default: begin
                    div_state <= softex_ctrl_pkg::DIV_DONE;
                end
            endcase
        end
    end

    // Saturates only for a zero denominator
    assign recip = (|quo_q[DEN_W-1:RECIP_W]) ? '1 : quo_q[RECIP_W-1:0];

    always_comb begin
        for (int i = 0; i < VECT_WIDTH; i++) begin
            prod[i] = PROD_W'(weight_i.weights[i]) * PROD_W'(recip);
            if (!weight_i.strb[i]) begin
                prob[i] = '0;
            end else if (prod[i][PROD_W-1:16] > PROD_W'(softex_num_pkg::PROB_MAX)) begin
                prob[i] = softex_num_pkg::PROB_MAX;
            end else begin
                prob[i] = prod[i][31:16];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_o <= 1'b0;
        end else if (clear_i) begin
            out_valid_o <= 1'b0;
        end else if (take_norm) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_norm) begin
            out_data_o <= prob;
            out_strb_o <= weight_i.strb;
        end
    end

    assign busy_o = out_valid_o || div_state == softex_ctrl_pkg::DIV_RUN;

endmodule

`default_nettype wire

// File: hdl/softex_execute.sv
//##########################################################################
// Base-2 exponent relative to the carried maximum. A score above that
// maximum is clamped to a weight of 1.0.
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

module softex_execute #(
    parameter int unsigned VECT_WIDTH = softex_num_pkg::VECT_WIDTH
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    softex_score_if.sink        score_i,
    softex_weight_if.source     weight_o,
    output logic                busy_o
);

    logic                                       valid_q;
    logic                                       accept;
    logic signed [softex_num_pkg::SCORE_W:0]    lane_diff [VECT_WIDTH];
    softex_num_pkg::weight_t [VECT_WIDTH-1:0]   lane_w;
    softex_num_pkg::den_t                       w_sum;
    softex_num_pkg::den_t                       den_q;

    always_comb begin
        w_sum = '0;
        for (int i = 0; i < VECT_WIDTH; i++) begin
            lane_diff[i] = score_i.max - score_i.scores[i];
            if (!score_i.strb[i]) begin
                lane_w[i] = '0;
            end else if (lane_diff[i] <= 0) begin
                lane_w[i] = softex_num_pkg::ONE_Q15;
            end else if (lane_diff[i] >= softex_num_pkg::EXP_RANGE) begin
                lane_w[i] = '0;
            end else begin
                lane_w[i] = softex_num_pkg::ONE_Q15 >> lane_diff[i][3:0];
            end
            w_sum = w_sum + softex_num_pkg::den_t'(lane_w[i]);
        end
    end

    assign accept        = score_i.valid && score_i.ready;
    assign score_i.ready = !valid_q || weight_o.ready;

    // A rise of the maximum by k halves the old sum k times before adding
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            den_q   <= '0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
            den_q   <= '0;
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
                if (score_i.mode == softex_ctrl_pkg::ACCUMULATE) begin
                    den_q <= (den_q >> score_i.shift) + w_sum;
                end
            end else if (weight_o.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            weight_o.strb    <= score_i.strb;
            weight_o.weights <= lane_w;
            weight_o.mode    <= score_i.mode;
        end
    end

    // den_q is updated together with the item register, so it is the item's own sum
    assign weight_o.den   = den_q;
    assign weight_o.valid = valid_q;
    assign busy_o         = valid_q;

endmodule

`default_nettype wire

// File: hdl/softex_decode.sv
//##########################################################################
// A lane is active only with both byte strobes set. NORMALIZE vectors leave
// the running maximum unchanged.
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

module softex_decode #(
    parameter int unsigned VECT_WIDTH = softex_num_pkg::VECT_WIDTH
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        clear_i,
    input  logic                                        in_valid_i,
    output logic                                        in_ready_o,
    input  softex_num_pkg::score_t [VECT_WIDTH-1:0]     in_data_i,
    input  logic [VECT_WIDTH*softex_num_pkg::STRB_PER_LANE-1:0] in_strb_i,
    input  softex_ctrl_pkg::mode_e                      mode_i,
    output softex_num_pkg::score_t                      max_o,
    output logic                                        busy_o,
    softex_score_if.source                              score_o
);

    localparam int unsigned SPL = softex_num_pkg::STRB_PER_LANE;

    logic [VECT_WIDTH-1:0]                  lane_strb;
    logic                                   any_lane;
    logic                                   has_max;
    logic                                   valid_q;
    logic                                   accept;
    softex_num_pkg::score_t                 vec_max;
    softex_num_pkg::score_t                 cur_max;
    softex_num_pkg::score_t                 new_max;
    logic signed [softex_num_pkg::SCORE_W:0] max_diff;
    softex_num_pkg::shift_t                 shift;

    for (genvar i = 0; i < VECT_WIDTH; i++) begin : gen_lane_strb
        assign lane_strb[i] = &in_strb_i[i*SPL +: SPL];
    end

    always_comb begin
        vec_max  = '0;
        any_lane = 1'b0;
        for (int i = 0; i < VECT_WIDTH; i++) begin
            if (lane_strb[i] && (!any_lane || in_data_i[i] > vec_max)) begin
                vec_max  = in_data_i[i];
                any_lane = 1'b1;
            end
        end
    end

    // The first active vector after a clear loads the maximum directly
    always_comb begin
        new_max = cur_max;
        if (mode_i == softex_ctrl_pkg::ACCUMULATE && any_lane) begin
            if (!has_max || vec_max > cur_max) begin
                new_max = vec_max;
            end
        end
        max_diff = '0;
        if (has_max) begin
            max_diff = new_max - cur_max;
        end
        if (max_diff > 17'sd32) begin
            shift = softex_num_pkg::SHIFT_SAT;
        end else begin
            shift = max_diff[softex_num_pkg::SHIFT_W-1:0];
        end
    end

    assign accept     = in_valid_i && in_ready_o;
    assign in_ready_o = !valid_q || score_o.ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            has_max <= 1'b0;
            cur_max <= '0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
            has_max <= 1'b0;
            cur_max <= '0;
        end else if (accept) begin
            valid_q <= 1'b1;
            cur_max <= new_max;
            if (mode_i == softex_ctrl_pkg::ACCUMULATE && any_lane) begin
                has_max <= 1'b1;
            end
        end else if (score_o.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            score_o.strb   <= lane_strb;
            score_o.scores <= in_data_i;
            score_o.max    <= new_max;
            score_o.shift  <= shift;
            score_o.mode   <= mode_i;
        end
    end

    assign score_o.valid = valid_q;
    assign max_o         = cur_max;
    assign busy_o        = valid_q;

endmodule

`default_nettype wire

// File: hdl/softex_stage_ifs.sv
//##########################################################################
// Stage-to-stage links. An item moves when valid and ready are both high.
//##########################################################################

`timescale 1ns/100ps
`default_nettype none

interface softex_score_if #(
    parameter int unsigned VECT_WIDTH = softex_num_pkg::VECT_WIDTH
);
    logic                                       valid;
    logic                                       ready;
    logic [VECT_WIDTH-1:0]                      strb;
    softex_num_pkg::score_t [VECT_WIDTH-1:0]    scores;
    softex_num_pkg::score_t                     max;
    softex_num_pkg::shift_t                     shift;
    softex_ctrl_pkg::mode_e                     mode;

    modport source (output valid, strb, scores, max, shift, mode, input ready);
    modport sink (input valid, strb, scores, max, shift, mode, output ready);
endinterface

interface softex_weight_if #(
    parameter int unsigned VECT_WIDTH = softex_num_pkg::VECT_WIDTH
);
    logic                                       valid;
    logic                                       ready;
    logic [VECT_WIDTH-1:0]                      strb;
    softex_num_pkg::weight_t [VECT_WIDTH-1:0]   weights;
    softex_num_pkg::den_t                       den;
    softex_ctrl_pkg::mode_e                     mode;

    modport source (output valid, strb, weights, den, mode, input ready);
    modport sink (input valid, strb, weights, den, mode, output ready);
endinterface

`default_nettype wire

// File: hdl/softex_ctrl_pkg.sv
//##########################################################################
// Control encodings: the per-item mode tag and the reciprocal divider FSM.
//##########################################################################

`default_nettype none

package softex_ctrl_pkg;

    // ACCUMULATE builds the maximum and denominator, NORMALIZE emits results
    typedef enum logic {
        ACCUMULATE = 1'b0,
        NORMALIZE  = 1'b1
    } mode_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

// File: hdl/softex_num_pkg.sv
//##########################################################################
// Integer number formats of the softmax datapath. Weights and probabilities
// are Q0.15; a weight of 1.0 needs the extra bit of weight_t.
//##########################################################################

`default_nettype none

package softex_num_pkg;

    // Default lane count, overridden through the top-level parameter
    parameter int unsigned VECT_WIDTH = 4;

    parameter int unsigned SCORE_W       = 16;
    parameter int unsigned STRB_PER_LANE = SCORE_W / 8;
    parameter int unsigned WEIGHT_W      = 17;
    parameter int unsigned SHIFT_W       = 6;
    parameter int unsigned DEN_W         = 32;
    parameter int unsigned RECIP_W       = 17;
    parameter int unsigned PROB_W        = 16;

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic        [WEIGHT_W-1:0] weight_t;
    typedef logic        [SHIFT_W-1:0] shift_t;
    typedef logic        [DEN_W-1:0] den_t;
    typedef logic        [RECIP_W-1:0] recip_t;
    typedef logic        [PROB_W-1:0] prob_t;

    parameter weight_t ONE_Q15   = 17'd32768;
    parameter shift_t  SHIFT_SAT = 6'd32;
    parameter prob_t   PROB_MAX  = 16'd32767;

    // Differences at or above this give a weight of 0
    parameter int EXP_RANGE = 16;

endpackage

`default_nettype wire
